// File: Bender.yml
package:
  name: fpu_mult

export_include_dirs:
  - design

sources:
  - design/fpu_mult_pkg.sv
  - design/fpu_mult_ctrl.sv
  - design/fpu_mult_exp_unit.sv
  - design/fpu_mult_sgf_mult.sv
  - design/fpu_mult_round.sv
  - design/fpu_mult_pack.sv
  - design/fpu_mult_top.sv
  - target: test
    files:
      - bench/fpu_mult_tb.sv

// File: bench/fpu_mult_tb.sv
`timescale 1ns/10ps
`include "fpu_mult_params.svh"

module fpu_mult_tb
    import fpu_mult_pkg::*;
;

    localparam int NUM_DIRECTED = 32;
    localparam int NUM_RANDOM   = 2000;
    // 20 cycles per operation plus reset margin
    localparam int CYCLE_LIMIT  = 20 * (NUM_DIRECTED + NUM_RANDOM) + 100;

    logic     clk;
    logic     rst_n_i;
    logic     begin_i;
    logic     ack_i;
    fp_word_t data_x_i;
    fp_word_t data_y_i;
    rmode_t   round_mode_i;
    fp_word_t result_o;
    logic     overflow_o;
    logic     underflow_o;
    logic     ready_o;

    // Expected response of the operation in flight
    fp_word_t exp_result;
    logic     exp_ovf;
    logic     exp_udf;

    int mismatch_cnt;
    int other_err_cnt;
    int check_cnt;
    int cycle_cnt;

    fpu_mult_top fpu_mult_top_i (
        .clk(clk), .rst_n_i(rst_n_i), .begin_i(begin_i), .ack_i(ack_i),
        .data_x_i(data_x_i), .data_y_i(data_y_i), .round_mode_i(round_mode_i),
        .result_o(result_o), .overflow_o(overflow_o), .underflow_o(underflow_o),
        .ready_o(ready_o));

    // 20 ns clock
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model, returns {overflow, underflow, result}
    ////////////////////////////////////////////////////////////

    function automatic logic [33:0] fp_mult_ref(input fp_word_t a, input fp_word_t b,
                                                input rmode_t mode);
        logic        sign;
        logic [47:0] prod;
        logic [23:0] sgf;
        logic        guard;
        logic        sticky;
        logic        inc;
        logic [24:0] sum;
        int          exp_val;
        fp_word_t    res;
        logic        ovf;
        logic        udf;
        begin
            sign = a[31] ^ b[31];
            // Zero or subnormal operand, no flags
            if ((a[30:23] == 8'h00) || (b[30:23] == 8'h00)) begin
                return {2'b00, sign, 31'b0};
            end
            prod = {24'b0, 1'b1, a[22:0]} * {24'b0, 1'b1, b[22:0]};
            exp_val = int'(a[30:23]) + int'(b[30:23]) - `FPU_BIAS;
            // Product in [2,4) moves the binary point
            if (prod[47]) begin
                sgf     = prod[47:24];
                guard   = prod[23];
                sticky  = |prod[22:0];
                exp_val = exp_val + 1;
            end else begin
                sgf    = prod[46:23];
                guard  = prod[22];
                sticky = |prod[21:0];
            end
            case (mode)
                2'b00:   inc = guard && (sticky || sgf[0]);
                2'b01:   inc = 1'b0;
                2'b10:   inc = !sign && (guard || sticky);
                default: inc = sign && (guard || sticky);
            endcase
            sum = {1'b0, sgf} + 25'(inc);
            // Carry out, shift back and bump exponent
            if (sum[24]) begin
                sgf     = sum[24:1];
                exp_val = exp_val + 1;
            end else begin
                sgf = sum[23:0];
            end
            ovf = (exp_val > `FPU_EXP_MAX);
            udf = (exp_val < 1);
            if (ovf) begin
                res = {sign, 8'hFF, 23'b0};
            end else if (udf) begin
                res = {sign, 31'b0};
            end else begin
                res = {sign, exp_val[7:0], sgf[22:0]};
            end
            return {ovf, udf, res};
        end
    endfunction

    // Half the time a mid-range exponent, else any bit pattern
    function automatic fp_word_t rand_operand();
        fp_word_t w;
        begin
            w = $urandom;
            if ($urandom % 2) begin
                w[30:23] = 8'(64 + $urandom % 128);
            end
            return w;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Response checker, outputs sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n_i && ready_o) begin
            check_cnt++;
            if (result_o !== exp_result) begin
                $display("Mismatch at %0t: result_o expected %h, got %h",
                         $time, exp_result, result_o);
                mismatch_cnt++;
            end
            if (overflow_o !== exp_ovf) begin
                $display("Mismatch at %0t: overflow_o expected %b, got %b",
                         $time, exp_ovf, overflow_o);
                mismatch_cnt++;
            end
            if (underflow_o !== exp_udf) begin
                $display("Mismatch at %0t: underflow_o expected %b, got %b",
                         $time, exp_udf, underflow_o);
                mismatch_cnt++;
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // One full handshake: begin pulse, wait, hold, ack
    task automatic run_op(input fp_word_t a, input fp_word_t b, input rmode_t mode,
                          input int ack_delay);
        logic [33:0] ref_val;
        fp_word_t    held_result;
        int          latency;
        begin
            ref_val    = fp_mult_ref(a, b, mode);
            exp_result = ref_val[31:0];
            exp_ovf    = ref_val[33];
            exp_udf    = ref_val[32];
            @(posedge clk);
            #2;
            data_x_i     = a;
            data_y_i     = b;
            round_mode_i = mode;
            begin_i      = 1'b1;
            @(posedge clk);
            #2;
            begin_i = 1'b0;
            latency = 1;
            while (!ready_o) begin
                @(posedge clk);
                #2;
                latency++;
            end
            if (latency > 8) begin
                $display("At %0t ready_o came %0d cycles after begin_i, more than 8",
                         $time, latency);
                other_err_cnt++;
            end
            held_result = result_o;
            // Back-pressure, nothing may move
            repeat (ack_delay) begin
                @(posedge clk);
                #2;
                if (ready_o !== 1'b1) begin
                    $display("At %0t ready_o dropped while ack_i was low", $time);
                    other_err_cnt++;
                end
                if (result_o !== held_result) begin
                    $display("Mismatch at %0t: result_o expected %h, got %h",
                             $time, held_result, result_o);
                    mismatch_cnt++;
                end
            end
            ack_i = 1'b1;
            @(posedge clk);
            #2;
            ack_i = 1'b0;
            if (ready_o !== 1'b0) begin
                $display("At %0t ready_o stayed high after ack_i", $time);
                other_err_cnt++;
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        begin_i       = 1'b0;
        ack_i         = 1'b0;
        data_x_i      = '0;
        data_y_i      = '0;
        round_mode_i  = '0;
        exp_result    = '0;
        exp_ovf       = 1'b0;
        exp_udf       = 1'b0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        check_cnt     = 0;
        cycle_cnt     = 0;
        void'($urandom(74));
        repeat (3) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // Exact products in every mode
        for (int m = 0; m < 4; m++) begin
            run_op(32'h3FC0_0000, 32'h4000_0000, rmode_t'(m), $urandom % 4);
            run_op(32'hC040_0000, 32'h3E80_0000, rmode_t'(m), $urandom % 4);
        end

        // Zero and subnormal operands, first one with an exponent sum below 1
        run_op(32'h0000_0000, 32'h3E80_0000, 2'b00, 1);
        run_op(32'h8000_0000, 32'h40A0_0000, 2'b01, 0);
        run_op(32'h0000_0001, 32'hC000_0000, 2'b10, 2);
        run_op(32'h40E0_0000, 32'h8000_0000, 2'b11, 3);

        // Range limits
        run_op(32'h7F00_0000, 32'h7F00_0000, 2'b00, 0);
        run_op(32'h7F00_0000, 32'hFF00_0000, 2'b01, 2);
        run_op(32'h0080_0000, 32'h0080_0000, 2'b10, 1);
        run_op(32'h0080_0000, 32'h8080_0000, 2'b11, 0);

        // Inexact, ties and all-ones carry
        for (int m = 0; m < 4; m++) begin
            run_op(32'h3F80_0001, 32'h3F80_0001, rmode_t'(m), $urandom % 4);
            run_op(32'h3F80_0001, 32'h3FC0_0000, rmode_t'(m), $urandom % 4);
            run_op(32'h3FFF_FFFE, 32'h3F80_0001, rmode_t'(m), $urandom % 4);
            run_op(32'hBFFF_FFFE, 32'h3F80_0001, rmode_t'(m), $urandom % 4);
        end

        // Random operands and modes
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_op(rand_operand(), rand_operand(), rmode_t'($urandom % 4), $urandom % 5);
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_cnt, mismatch_cnt, other_err_cnt);
        if ((mismatch_cnt == 0) && (other_err_cnt == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: design/fpu_mult_ctrl.sv
`timescale 1ns/10ps

module fpu_mult_ctrl
    import fpu_mult_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,
    input  logic begin_i,
    input  logic ack_i,
    input  logic round_carry_i,
    output logic ld_ops_o,
    output logic ld_mult_o,
    output logic ld_exp_o,
    output logic ld_norm_o,
    output logic ld_inc_o,
    output logic ld_renorm_o,
    output logic ld_pack_o,
    output logic ready_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        ready_q;

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                // Start request only looked at here
                if (begin_i) begin
                    state_d = LOAD_OPS;
                end
            end
            LOAD_OPS: state_d = MULT;
            MULT:     state_d = EXP_SUM;
            EXP_SUM:  state_d = NORM;
            NORM:     state_d = ROUND;
            // Carry out of the increment needs one more shift
            ROUND:    state_d = round_carry_i ? RENORM : PACK;
            RENORM:   state_d = PACK;
            PACK:     state_d = DONE;
            DONE: begin
                // Hold result until acknowledged
                if (ack_i) begin
                    state_d = IDLE;
                end
            end
            default:  state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Load strobes, one per datapath step
    ////////////////////////////////////////////////////////////

    assign ld_ops_o    = (state_q == LOAD_OPS);
    assign ld_mult_o   = (state_q == MULT);
    assign ld_exp_o    = (state_q == EXP_SUM);
    assign ld_norm_o   = (state_q == NORM);
    assign ld_inc_o    = (state_q == ROUND);
    assign ld_renorm_o = (state_q == RENORM);
    assign ld_pack_o   = (state_q == PACK);

    // Ready level, set as result register loads, cleared on ack
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ready_q <= 1'b0;
        end else if (state_q == PACK) begin
            ready_q <= 1'b1;
        end else if ((state_q == DONE) && ack_i) begin
            ready_q <= 1'b0;
        end
    end

    assign ready_o = ready_q;

    // Datapath steps never overlap
    a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ld_ops_o, ld_mult_o, ld_exp_o, ld_norm_o,
                  ld_inc_o, ld_renorm_o, ld_pack_o}));

    // Ready level tracks the waiting state
    a_ready_done : assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |-> (state_q == DONE));

endmodule

// File: design/fpu_mult_exp_unit.sv
`timescale 1ns/10ps
`include "fpu_mult_params.svh"

module fpu_mult_exp_unit
    import fpu_mult_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,
    input  logic ld_exp_i,
    input  logic ld_renorm_i,
    input  exp_t exp_a_i,
    input  exp_t exp_b_i,
    input  logic prod_msb_i,
    output exp_t exp_o,
    output logic overflow_o,
    output logic underflow_o
);

    exp_ext_t exp_q;
    exp_ext_t exp_sum_w;
    // Set once an exponent has been computed
    logic     exp_vld_q;

    // Ea + Eb - bias, plus one when product lies in [2,4)
    assign exp_sum_w = exp_ext_t'({2'b00, exp_a_i})
                     + exp_ext_t'({2'b00, exp_b_i})
                     - exp_ext_t'(`FPU_BIAS)
                     + exp_ext_t'(prod_msb_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exp_q     <= '0;
            exp_vld_q <= 1'b0;
        end else if (ld_exp_i) begin
            exp_q     <= exp_sum_w;
            exp_vld_q <= 1'b1;
        end else if (ld_renorm_i) begin
            // Rounding carried into a new binade
            exp_q <= exp_q + exp_ext_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Range flags
    ////////////////////////////////////////////////////////////

    // Beyond largest finite exponent
    assign overflow_o  = exp_vld_q && (exp_q > exp_ext_t'(`FPU_EXP_MAX));
    // Below 1, subnormal range gets flushed
    assign underflow_o = exp_vld_q && (exp_q < exp_ext_t'(1));

    // Low bits only, valid when neither flag is set
    assign exp_o = exp_q[`FPU_EW-1:0];

    a_flags_excl : assert property (@(posedge clk) disable iff (!rst_n_i)
        !(overflow_o && underflow_o));

endmodule

// File: design/fpu_mult_pack.sv
`timescale 1ns/10ps
`include "fpu_mult_params.svh"

module fpu_mult_pack
    import fpu_mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     ld_pack_i,
    input  logic     sign_i,
    input  logic     zero_i,
    input  logic     overflow_i,
    input  logic     underflow_i,
    input  exp_t     exp_i,
    input  sgf_t     sgf_i,
    output fp_word_t result_o
);

    fp_word_t result_q;
    fp_word_t result_d;

    ////////////////////////////////////////////////////////////
    // Result selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (zero_i) begin
            // Zero or subnormal operand
            result_d = {sign_i, {(`FPU_W-1){1'b0}}};
        end else if (overflow_i) begin
            // Signed infinity
            result_d = {sign_i, {`FPU_EW{1'b1}}, {`FPU_SW{1'b0}}};
        end else if (underflow_i) begin
            // Flush to signed zero
            result_d = {sign_i, {(`FPU_W-1){1'b0}}};
        end else begin
            // Hidden bit dropped
            result_d = {sign_i, exp_i, sgf_i[`FPU_SW-1:0]};
        end
    end

    // Held until next operation reaches PACK
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_q <= '0;
        end else if (ld_pack_i) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;

endmodule

// File: design/fpu_mult_params.svh
`ifndef FPU_MULT_PARAMS_SVH
`define FPU_MULT_PARAMS_SVH

////////////////////////////////////////////////////////////
// Binary32 format widths
////////////////////////////////////////////////////////////

// Packed word
`define FPU_W 32
// Biased exponent field
`define FPU_EW 8
// Stored fraction, hidden bit excluded
`define FPU_SW 23

// Exponent bias and largest finite biased exponent
`define FPU_BIAS 127
`define FPU_EXP_MAX 254

`endif

// File: design/fpu_mult_pkg.sv
`include "fpu_mult_params.svh"

package fpu_mult_pkg;

    // One packed binary32 value
    typedef logic [`FPU_W-1:0] fp_word_t;
    // Biased exponent field
    typedef logic [`FPU_EW-1:0] exp_t;
    // Working exponent, two spare bits for sign and overflow
    typedef logic signed [`FPU_EW+1:0] exp_ext_t;
    // Significand with hidden bit
    typedef logic [`FPU_SW:0] sgf_t;
    // Full 48-bit significand product
    typedef logic [2*(`FPU_SW+1)-1:0] prod_t;
    // 00 nearest even, 01 toward zero, 10 toward +inf, 11 toward -inf
    typedef logic [1:0] rmode_t;

    // Controller sequence, one datapath step per state
    typedef enum logic [3:0] {
        IDLE,
        LOAD_OPS,
        MULT,
        EXP_SUM,
        NORM,
        ROUND,
        RENORM,
        PACK,
        DONE
    } ctrl_state_t;

endpackage

// File: design/fpu_mult_round.sv
`timescale 1ns/10ps
`include "fpu_mult_params.svh"

module fpu_mult_round
    import fpu_mult_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   ld_norm_i,
    input  logic   ld_inc_i,
    input  logic   ld_renorm_i,
    input  prod_t  prod_i,
    input  logic   prod_msb_i,
    input  logic   sign_i,
    input  rmode_t rmode_i,
    output sgf_t   sgf_o,
    output logic   round_carry_o
);

    prod_t                shift_w;
    sgf_t                 sgf_q;
    logic                 guard_q;
    logic                 sticky_q;
    logic                 carry_q;
    logic                 inc_w;
    logic [`FPU_SW+1:0]   sum_w;

    ////////////////////////////////////////////////////////////
    // Normalization
    ////////////////////////////////////////////////////////////

    // Leading one moved to the top bit
    assign shift_w = prod_msb_i ? prod_i : (prod_i << 1);

    ////////////////////////////////////////////////////////////
    // Round decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (rmode_i)
            // Nearest, ties go to even lsb
            2'b00:   inc_w = guard_q && (sticky_q || sgf_q[0]);
            // Truncate
            2'b01:   inc_w = 1'b0;
            // Toward +inf, positive inexact bumps up
            2'b10:   inc_w = !sign_i && (guard_q || sticky_q);
            // Toward -inf, negative inexact bumps magnitude
            2'b11:   inc_w = sign_i && (guard_q || sticky_q);
            default: inc_w = 1'b0;
        endcase
    end

    assign sum_w = {1'b0, sgf_q} + {{(`FPU_SW+1){1'b0}}, inc_w};

    // Carry of pending increment, sampled by the controller in ROUND
    assign round_carry_o = sum_w[`FPU_SW+1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sgf_q    <= '0;
            guard_q  <= 1'b0;
            sticky_q <= 1'b0;
            carry_q  <= 1'b0;
        end else if (ld_norm_i) begin
            sgf_q    <= shift_w[2*`FPU_SW+1 : `FPU_SW+1];
            guard_q  <= shift_w[`FPU_SW];
            // Everything below guard
            sticky_q <= |shift_w[`FPU_SW-1:0];
            carry_q  <= 1'b0;
        end else if (ld_inc_i) begin
            sgf_q   <= sum_w[`FPU_SW:0];
            carry_q <= sum_w[`FPU_SW+1];
        end else if (ld_renorm_i) begin
            // Carry becomes the new hidden bit
            sgf_q <= {carry_q, sgf_q[`FPU_SW:1]};
        end
    end

    assign sgf_o = sgf_q;

endmodule

// File: design/fpu_mult_sgf_mult.sv
`timescale 1ns/10ps
`include "fpu_mult_params.svh"

module fpu_mult_sgf_mult
    import fpu_mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     ld_mult_i,
    input  fp_word_t op_a_i,
    input  fp_word_t op_b_i,
    output prod_t    prod_o,
    output logic     sign_o,
    output logic     zero_o
);

    sgf_t  sgf_a_w;
    sgf_t  sgf_b_w;
    prod_t prod_q;
    logic  sign_q;
    logic  zero_q;

    // Hidden bit restored
    assign sgf_a_w = {1'b1, op_a_i[`FPU_SW-1:0]};
    assign sgf_b_w = {1'b1, op_b_i[`FPU_SW-1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            prod_q <= '0;
            sign_q <= 1'b0;
            zero_q <= 1'b0;
        end else if (ld_mult_i) begin
            prod_q <= prod_t'(sgf_a_w) * prod_t'(sgf_b_w);
            sign_q <= op_a_i[`FPU_W-1] ^ op_b_i[`FPU_W-1];
            // Zero exponent field, zero or subnormal
            zero_q <= (op_a_i[`FPU_W-2 -: `FPU_EW] == '0) ||
                      (op_b_i[`FPU_W-2 -: `FPU_EW] == '0);
        end
    end

    assign prod_o = prod_q;
    assign sign_o = sign_q;
    assign zero_o = zero_q;

    // Two normal significands give at least 2^46
    a_prod_norm : assert property (@(posedge clk) disable iff (!rst_n_i)
        ($past(ld_mult_i) && !zero_o) |-> (|prod_o[2*`FPU_SW+1 -: 2]));

endmodule

// File: design/fpu_mult_top.sv
`timescale 1ns/10ps
`include "fpu_mult_params.svh"

module fpu_mult_top
    import fpu_mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     begin_i,
    input  logic     ack_i,
    input  fp_word_t data_x_i,
    input  fp_word_t data_y_i,
    input  rmode_t   round_mode_i,
    output fp_word_t result_o,
    output logic     overflow_o,
    output logic     underflow_o,
    output logic     ready_o
);

    // Strobes from controller
    logic ld_ops, ld_mult, ld_exp, ld_norm, ld_inc, ld_renorm, ld_pack;
    // Captured operands and mode
    fp_word_t op_a_q, op_b_q;
    rmode_t   rmode_q;
    // Datapath links
    prod_t prod_w;
    logic  sign_w, zero_w, round_carry_w, ovf_w, udf_w;
    exp_t  exp_w;
    sgf_t  sgf_w;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_a_q  <= '0;
            op_b_q  <= '0;
            rmode_q <= '0;
        end else if (ld_ops) begin
            op_a_q  <= data_x_i;
            op_b_q  <= data_y_i;
            rmode_q <= round_mode_i;
        end
    end

    fpu_mult_ctrl u_ctrl (
        .clk(clk), .rst_n_i(rst_n_i), .begin_i(begin_i), .ack_i(ack_i),
        .round_carry_i(round_carry_w), .ld_ops_o(ld_ops), .ld_mult_o(ld_mult),
        .ld_exp_o(ld_exp), .ld_norm_o(ld_norm), .ld_inc_o(ld_inc),
        .ld_renorm_o(ld_renorm), .ld_pack_o(ld_pack), .ready_o(ready_o));

    fpu_mult_sgf_mult u_sgf_mult (
        .clk(clk), .rst_n_i(rst_n_i), .ld_mult_i(ld_mult), .op_a_i(op_a_q),
        .op_b_i(op_b_q), .prod_o(prod_w), .sign_o(sign_w), .zero_o(zero_w));

    fpu_mult_exp_unit u_exp_unit (
        .clk(clk), .rst_n_i(rst_n_i), .ld_exp_i(ld_exp), .ld_renorm_i(ld_renorm),
        .exp_a_i(op_a_q[`FPU_W-2 -: `FPU_EW]), .exp_b_i(op_b_q[`FPU_W-2 -: `FPU_EW]),
        .prod_msb_i(prod_w[2*`FPU_SW+1]), .exp_o(exp_w), .overflow_o(ovf_w),
        .underflow_o(udf_w));

    fpu_mult_round u_round (
        .clk(clk), .rst_n_i(rst_n_i), .ld_norm_i(ld_norm), .ld_inc_i(ld_inc),
        .ld_renorm_i(ld_renorm), .prod_i(prod_w), .prod_msb_i(prod_w[2*`FPU_SW+1]),
        .sign_i(sign_w), .rmode_i(rmode_q), .sgf_o(sgf_w),
        .round_carry_o(round_carry_w));

    fpu_mult_pack u_pack (
        .clk(clk), .rst_n_i(rst_n_i), .ld_pack_i(ld_pack), .sign_i(sign_w),
        .zero_i(zero_w), .overflow_i(ovf_w), .underflow_i(udf_w), .exp_i(exp_w),
        .sgf_i(sgf_w), .result_o(result_o));

    // Zero product raises no range flag
    assign overflow_o  = ovf_w && !zero_w;
    assign underflow_o = udf_w && !zero_w;

endmodule

// File: fpu_mult_top.f
+incdir+design
design/fpu_mult_pkg.sv
design/fpu_mult_ctrl.sv
design/fpu_mult_exp_unit.sv
design/fpu_mult_sgf_mult.sv
design/fpu_mult_round.sv
design/fpu_mult_pack.sv
design/fpu_mult_top.sv
bench/fpu_mult_tb.sv
